// ==== Makefile ====
SIM := obj_dir/Vtb_mmc_wb

$(SIM): mmc_wb.f $(shell grep -v '^+' mmc_wb.f)
	verilator --binary --assert -Wno-fatal --top-module tb_mmc_wb -f mmc_wb.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^Finished with no errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== mmc_wb.f ====
verilog/mmc_bus_pkg.sv
verilog/mmc_map_pkg.sv
verilog/mmc_addr_decode.sv
verilog/mmc_txn_tracker.sv
verilog/mmc_resp_mux.sv
verilog/mmc_wb.sv
verif/tb_wb_slave.sv
verif/tb_mmc_wb.sv

// ==== verif/tb_mmc_wb.sv ====
`timescale 1ns/100ps

module tb_mmc_wb;

  import mmc_bus_pkg::*;
  import mmc_map_pkg::*;

  localparam int NUM_XFERS   = 300;
  localparam int TIMEOUT_CYC = NUM_XFERS * 12 + 100;

  logic                  clk;
  logic                  rst;
  logic [ADR_W-1:0]      cpu_adr_i;
  logic [DAT_W-1:0]      cpu_dat_i;
  logic                  cpu_we_i;
  logic [SEL_W-1:0]      cpu_sel_i;
  logic                  cpu_stb_i;
  logic                  cpu_cyc_i;
  logic                  cpu_ack_o;
  logic                  cpu_err_o;
  logic [DAT_W-1:0]      cpu_dat_o;
  logic                  cpu_stall_o;
  logic [ADR_W-1:0]      slv_adr_o [NUM_SLAVES];
  logic [DAT_W-1:0]      slv_dat_o [NUM_SLAVES];
  logic [NUM_SLAVES-1:0] slv_we_o;
  logic [SEL_W-1:0]      slv_sel_o [NUM_SLAVES];
  logic [NUM_SLAVES-1:0] slv_stb_o;
  logic [NUM_SLAVES-1:0] slv_cyc_o;
  logic [NUM_SLAVES-1:0] slv_ack_i;
  logic [NUM_SLAVES-1:0] slv_err_i;
  logic [DAT_W-1:0]      slv_dat_i [NUM_SLAVES];
  logic [NUM_SLAVES-1:0] slv_stall_i;
  logic [NUM_SLAVES-1:0] stall_req;
  logic [1:0]            lat_req [NUM_SLAVES];
  logic [31:0]           lfsr;
  int                    errors;
  int                    cycles = 0;
  logic                  quiet;
  tgt_t                  last_tgt;
  logic [DAT_W-1:0]      model [NUM_SLAVES][16];
  // One entry per accepted transfer as {unmapped, read, data}.
  logic [DAT_W+1:0]      exp_q [$];

  mmc_wb mmc_wb_inst (.*);

  for (genvar g = 0; g < NUM_SLAVES; g++)
  begin : g_slave
    tb_wb_slave #(.ID(g)) slave_inst (
      .clk     (clk),
      .rst     (rst),
      .adr_i   (slv_adr_o[g]),
      .dat_i   (slv_dat_o[g]),
      .we_i    (slv_we_o[g]),
      .sel_i   (slv_sel_o[g]),
      .stb_i   (slv_stb_o[g]),
      .cyc_i   (slv_cyc_o[g]),
      .stall_i (stall_req[g]),
      .lat_i   (lat_req[g]),
      .ack_o   (slv_ack_i[g]),
      .err_o   (slv_err_i[g]),
      .dat_o   (slv_dat_i[g]),
      .stall_o (slv_stall_i[g])
    );
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic tgt_t window_of(input logic [ADR_W-1:0] adr);
    for (int i = 0; i < NUM_SLAVES; i++)
      if (adr >= SLV_BASE[i] && adr <= SLV_LIMIT[i])
        return tgt_t'(i);
    return TGT_NULL;
  endfunction

  // Mostly mapped words, one pick in four lands just past a window.
  function automatic logic [ADR_W-1:0] pick_addr();
    int               win;
    logic [ADR_W-1:0] ofs;
    win = int'(rand_bits(3));
    ofs = ADR_W'(rand_bits(4)) << 2;
    if (win >= 6)
      return SLV_LIMIT[int'(rand_bits(2))] + 1 + ofs;
    return SLV_BASE[win % NUM_SLAVES] + ofs;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic tick();
    @(posedge clk);
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      stall_req[i] <= (rand_bits(2) == 0);
      lat_req[i]   <= 2'(rand_bits(2));
    end
  endtask

  // Hold the request until the DUT takes it.
  task automatic xfer(input logic [ADR_W-1:0] adr, input logic we);
    cpu_adr_i <= adr;
    cpu_we_i  <= we;
    cpu_dat_i <= rand_bits(DAT_W);
    cpu_sel_i <= we ? SEL_W'(rand_bits(SEL_W)) : '1;
    cpu_stb_i <= 1'b1;
    tick();
    while (cpu_stall_o)
      tick();
  endtask

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  always @(posedge clk)
  begin
    tgt_t             t;
    logic [DAT_W+1:0] e;
    logic [ADR_W-1:0] o;
    int               pending;
    logic             exp_stall;
    t = window_of(cpu_adr_i);
    pending = exp_q.size();
    if (rst)
      for (int s = 0; s < NUM_SLAVES; s++)
        for (int w = 0; w < 16; w++)
          model[s][w] = 32'hA500_0000 ^ (32'(s) << 16) ^ (32'(w) * 32'h0000_1011);
    for (int i = 0; i < NUM_SLAVES; i++)
      if (slv_stb_o[i])
      begin
        a_route: assert (t == tgt_t'(i))
          else report_error($sformatf("ERR slv_stb_o %h cpu_adr_i %h", slv_stb_o, cpu_adr_i));
        a_offset: assert (slv_adr_o[i] == cpu_adr_i - SLV_BASE[i])
          else report_error($sformatf("ERR slv_adr_o %h expected %h",
            slv_adr_o[i], cpu_adr_i - SLV_BASE[i]));
      end
    if (!rst && (cpu_ack_o || cpu_err_o))
    begin
      a_resp_known: assert (!quiet && pending != 0)
        else report_error("Acknowledge or error seen with no transfer outstanding");
      if (pending != 0)
      begin
        e = exp_q.pop_front();
        a_resp_err: assert (cpu_err_o == e[DAT_W+1])
          else report_error($sformatf("ERR cpu_err_o %h expected %h", cpu_err_o, e[DAT_W+1]));
        a_rd_data: assert (!e[DAT_W] || cpu_dat_o == e[DAT_W-1:0])
          else report_error($sformatf("ERR cpu_dat_o %h expected %h", cpu_dat_o, e[DAT_W-1:0]));
      end
    end
    // A new target waits for an empty pipeline, the same one for a free slot.
    if (!rst && cpu_cyc_i && cpu_stb_i)
    begin
      exp_stall = (t != TGT_NULL && stall_req[t]) ||
        !(pending == 0 || (t == last_tgt && pending < MAX_OUTSTANDING));
      a_stall: assert (cpu_stall_o == exp_stall)
        else report_error($sformatf("ERR cpu_stall_o %h expected %h", cpu_stall_o, exp_stall));
    end
    if (!rst && cpu_cyc_i && cpu_stb_i && !cpu_stall_o)
    begin
      e = {(t == TGT_NULL), (!cpu_we_i && t != TGT_NULL), {DAT_W{1'b0}}};
      if (t != TGT_NULL)
      begin
        o = cpu_adr_i - SLV_BASE[t];
        e[DAT_W-1:0] = model[t][o[5:2]];
        for (int b = 0; b < SEL_W; b++)
          if (cpu_we_i && cpu_sel_i[b])
            model[t][o[5:2]][8*b +: 8] = cpu_dat_i[8*b +: 8];
      end
      exp_q.push_back(e);
      last_tgt = t;
      quiet = 1'b0;
    end
    // A dropped bus cycle abandons every open transfer.
    if (rst || !cpu_cyc_i)
    begin
      quiet = 1'b1;
      exp_q.delete();
    end
  end

  a_null_resp: assert property (
    @(posedge clk) disable iff (rst)
    (cpu_cyc_i && cpu_stb_i && !cpu_stall_o && window_of(cpu_adr_i) == TGT_NULL)
      |=> (cpu_ack_o && cpu_err_o && cpu_dat_o == '0)
  ) else report_error($sformatf("ERR unmapped cpu_ack_o %h cpu_err_o %h cpu_dat_o %h",
    $sampled(cpu_ack_o), $sampled(cpu_err_o), $sampled(cpu_dat_o)));

  initial
  begin
    lfsr      = 32'h3f9e30ba;
    errors    = 0;
    rst       = 1'b1;
    cpu_adr_i = '0;
    cpu_dat_i = '0;
    cpu_we_i  = 1'b0;
    cpu_sel_i = '0;
    cpu_stb_i = 1'b0;
    cpu_cyc_i = 1'b0;
    stall_req = '0;
    lat_req   = '{default: 2'd0};
    repeat (8)
      tick();
    rst       <= 1'b0;
    cpu_cyc_i <= 1'b1;
    for (int n = 0; n < NUM_XFERS; n++)
    begin
      xfer(pick_addr(), rand_bits(1) != 0);
      if (rand_bits(2) == 0)
      begin
        cpu_stb_i <= 1'b0;
        tick();
      end
      // Drop the bus cycle, often with responses still due.
      if (n % 50 == 49)
      begin
        cpu_stb_i <= 1'b0;
        cpu_cyc_i <= 1'b0;
        repeat (4)
          tick();
        cpu_cyc_i <= 1'b1;
      end
    end
    cpu_stb_i <= 1'b0;
    while (exp_q.size() != 0)
      tick();
    repeat (4)
      tick();
    $display("Transfers: %0d, errors: %0d", NUM_XFERS, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    wait (cycles >= TIMEOUT_CYC);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verif/tb_wb_slave.sv ====
`timescale 1ns/100ps

module tb_wb_slave #(
  parameter int ID = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [mmc_bus_pkg::ADR_W-1:0] adr_i,
  input  logic [mmc_bus_pkg::DAT_W-1:0] dat_i,
  input  logic                          we_i,
  input  logic [mmc_bus_pkg::SEL_W-1:0] sel_i,
  input  logic                          stb_i,
  input  logic                          cyc_i,
  input  logic                          stall_i,
  input  logic [1:0]                    lat_i,
  output logic                          ack_o,
  output logic                          err_o,
  output logic [mmc_bus_pkg::DAT_W-1:0] dat_o,
  output logic                          stall_o
);

  import mmc_bus_pkg::*;

  logic [DAT_W-1:0] mem [16];
  logic [DAT_W-1:0] rdat_q [$];
  int               wait_q [$];

  assign stall_o = stall_i;
  assign err_o   = 1'b0;

  // Responses leave in accept order, each 1 + lat_i cycles after accept.
  always @(posedge clk)
  begin
    ack_o <= 1'b0;
    if (rst)
      for (int i = 0; i < 16; i++)
        mem[i] = 32'hA500_0000 ^ (32'(ID) << 16) ^ (32'(i) * 32'h0000_1011);
    if (rst || !cyc_i)
    begin
      rdat_q.delete();
      wait_q.delete();
    end
    else
    begin
      if (wait_q.size() != 0 && wait_q[0] == 0)
      begin
        ack_o <= 1'b1;
        dat_o <= rdat_q.pop_front();
        wait_q.delete(0);
      end
      else if (wait_q.size() != 0)
        wait_q[0] = wait_q[0] - 1;
      if (stb_i && !stall_i)
      begin
        // Read data is taken at accept time.
        rdat_q.push_back(we_i ? '0 : mem[adr_i[5:2]]);
        wait_q.push_back(int'(lat_i));
        for (int b = 0; b < SEL_W; b++)
          if (we_i && sel_i[b])
            mem[adr_i[5:2]][8*b +: 8] = dat_i[8*b +: 8];
      end
    end
  end

endmodule

// ==== verilog/mmc_addr_decode.sv ====
`timescale 1ns/100ps

module mmc_addr_decode (
  input  logic [mmc_bus_pkg::ADR_W-1:0] adr_i,
  output mmc_bus_pkg::tgt_t             tgt_o,
  output logic [mmc_bus_pkg::ADR_W-1:0] ofs_o
);

  import mmc_bus_pkg::*;
  import mmc_map_pkg::*;

  logic [NUM_SLAVES-1:0] hit;

  always_comb
  begin
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      hit[i] = (adr_i >= SLV_BASE[i]) && (adr_i <= SLV_LIMIT[i]);
    end
  end

  // Scan downwards so the lowest matching window wins.
  always_comb
  begin
    tgt_o = TGT_NULL;
    ofs_o = adr_i;
    for (int i = NUM_SLAVES - 1; i >= 0; i--)
    begin
      if (hit[i])
      begin
        tgt_o = tgt_t'(i);
        ofs_o = adr_i - SLV_BASE[i];
      end
    end
  end

  // Windows of the map must not overlap.
  always_comb
  begin
    a_one_window: assert ($onehot0(hit))
      else $error("address %h hits windows %b", adr_i, hit);
  end

endmodule

// ==== verilog/mmc_bus_pkg.sv ====
package mmc_bus_pkg;

  // Wishbone B4 port widths.
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;
  localparam int SEL_W = 4;

  // Mapped slaves behind the interconnect.
  localparam int NUM_SLAVES = 4;

  // Index of a response source.
  // Values below NUM_SLAVES select a slave.
  typedef logic [2:0] tgt_t;

  // Address hit no window.
  localparam tgt_t TGT_NULL = 3'd4;

endpackage

// ==== verilog/mmc_map_pkg.sv ====
package mmc_map_pkg;

  // Slave numbers, also the index into the slave port arrays.
  localparam mmc_bus_pkg::tgt_t SLV_MEM  = 3'd0;
  localparam mmc_bus_pkg::tgt_t SLV_DDR3 = 3'd1;
  localparam mmc_bus_pkg::tgt_t SLV_LED  = 3'd2;
  localparam mmc_bus_pkg::tgt_t SLV_UART = 3'd3;

  // Window base addresses.
  localparam logic [mmc_bus_pkg::ADR_W-1:0] SLV_BASE [mmc_bus_pkg::NUM_SLAVES] = '{
    SLV_MEM:  32'h0000_0000,
    SLV_DDR3: 32'h1000_0000,
    SLV_LED:  32'hC000_0000,
    SLV_UART: 32'hC304_0000
  };

  // Inclusive upper bound of each window.
  localparam logic [mmc_bus_pkg::ADR_W-1:0] SLV_LIMIT [mmc_bus_pkg::NUM_SLAVES] = '{
    SLV_MEM:  32'h0000_7FFF,
    SLV_DDR3: 32'h13FF_FFFF,
    SLV_LED:  32'hC000_FFFF,
    SLV_UART: 32'hC304_FFFF
  };

  // Transfers in flight to one owner.
  localparam int MAX_OUTSTANDING = 4;

  // Counter has to hold MAX_OUTSTANDING itself.
  localparam int CNT_W = 3;

endpackage

// ==== verilog/mmc_resp_mux.sv ====
`timescale 1ns/100ps

module mmc_resp_mux (
  input  logic                                clk,
  input  logic                                rst,

  input  mmc_bus_pkg::tgt_t                   owner_i,
  input  logic                                null_accept_i,

  input  logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_ack_i,
  input  logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_err_i,
  input  logic [mmc_bus_pkg::DAT_W-1:0]       slv_dat_i [mmc_bus_pkg::NUM_SLAVES],

  output logic                                ack_o,
  output logic                                err_o,
  output logic [mmc_bus_pkg::DAT_W-1:0]       dat_o,
  output logic                                resp_done_o
);

  import mmc_bus_pkg::*;

  logic                  null_ack;
  logic [NUM_SLAVES-1:0] owner_mask;

  // Unmapped transfer ends with an error one cycle after accept.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      null_ack <= 1'b0;
    end
    else
    begin
      null_ack <= null_accept_i;
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      owner_mask[i] = (owner_i == tgt_t'(i));
    end
  end

  always_comb
  begin
    ack_o = 1'b0;
    err_o = 1'b0;
    dat_o = '0;
    if (null_ack)
    begin
      ack_o = 1'b1;
      err_o = 1'b1;
    end
    else
    begin
      for (int i = 0; i < NUM_SLAVES; i++)
      begin
        if (owner_mask[i])
        begin
          ack_o = slv_ack_i[i];
          err_o = slv_err_i[i];
          dat_o = slv_dat_i[i];
        end
      end
    end
  end

  assign resp_done_o = ack_o | err_o;

  // Only the owner may answer, else ordering is broken.
  a_owner_only: assert property (
    @(posedge clk) disable iff (rst)
    ((slv_ack_i | slv_err_i) & ~owner_mask) == '0
  ) else $error("response from non-owner, ack %b err %b", slv_ack_i, slv_err_i);

endmodule

// ==== verilog/mmc_txn_tracker.sv ====
`timescale 1ns/100ps

module mmc_txn_tracker (
  input  logic               clk,
  input  logic               rst,

  input  logic               cyc_i,
  input  logic               stb_i,
  input  mmc_bus_pkg::tgt_t  tgt_i,
  input  logic               tgt_stall_i,
  input  logic               resp_done_i,

  output logic               issue_o,
  output logic               accept_o,
  output logic               stall_o,
  output mmc_bus_pkg::tgt_t  owner_o
);

  import mmc_bus_pkg::*;
  import mmc_map_pkg::*;

  logic [CNT_W-1:0] cnt;
  tgt_t             owner;
  logic             block;

  // A new target waits until every older response is back.
  always_comb
  begin
    block = 1'b1;
    if (cnt == '0)
    begin
      block = 1'b0;
    end
    else if ((tgt_i == owner) && (cnt < CNT_W'(MAX_OUTSTANDING)))
    begin
      block = 1'b0;
    end
  end

  assign issue_o  = cyc_i & stb_i & ~block;
  assign accept_o = issue_o & ~tgt_stall_i;
  assign stall_o  = block | tgt_stall_i;
  assign owner_o  = owner;

  // Accept and response may land in the same cycle.
  always_ff @(posedge clk)
  begin
    if (rst || !cyc_i)
    begin
      cnt <= '0;
    end
    else
    begin
      cnt <= cnt + CNT_W'(accept_o) - CNT_W'(resp_done_i);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner <= TGT_NULL;
    end
    else if (accept_o)
    begin
      owner <= tgt_i;
    end
  end

  a_cnt_max: assert property (
    @(posedge clk) disable iff (rst)
    cnt <= CNT_W'(MAX_OUTSTANDING)
  ) else $error("outstanding count %0d above limit", cnt);

  // Each response must match a transfer that is still open.
  a_done_pending: assert property (
    @(posedge clk) disable iff (rst)
    resp_done_i |-> (cnt != '0)
  ) else $error("response with no outstanding transfer");

endmodule

// ==== verilog/mmc_wb.sv ====
`timescale 1ns/100ps

module mmc_wb (
  input  logic                                clk,
  input  logic                                rst,

  input  logic [mmc_bus_pkg::ADR_W-1:0]       cpu_adr_i,
  input  logic [mmc_bus_pkg::DAT_W-1:0]       cpu_dat_i,
  input  logic                                cpu_we_i,
  input  logic [mmc_bus_pkg::SEL_W-1:0]       cpu_sel_i,
  input  logic                                cpu_stb_i,
  input  logic                                cpu_cyc_i,

  output logic                                cpu_ack_o,
  output logic                                cpu_err_o,
  output logic [mmc_bus_pkg::DAT_W-1:0]       cpu_dat_o,
  output logic                                cpu_stall_o,

  output logic [mmc_bus_pkg::ADR_W-1:0]       slv_adr_o [mmc_bus_pkg::NUM_SLAVES],
  output logic [mmc_bus_pkg::DAT_W-1:0]       slv_dat_o [mmc_bus_pkg::NUM_SLAVES],
  output logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_we_o,
  output logic [mmc_bus_pkg::SEL_W-1:0]       slv_sel_o [mmc_bus_pkg::NUM_SLAVES],
  output logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_stb_o,
  output logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_cyc_o,

  input  logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_ack_i,
  input  logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_err_i,
  input  logic [mmc_bus_pkg::DAT_W-1:0]       slv_dat_i [mmc_bus_pkg::NUM_SLAVES],
  input  logic [mmc_bus_pkg::NUM_SLAVES-1:0]  slv_stall_i
);

  import mmc_bus_pkg::*;

  tgt_t             tgt;
  tgt_t             owner;
  logic [ADR_W-1:0] ofs;
  logic             issue;
  logic             accept;
  logic             tgt_stall;
  logic             null_accept;
  logic             resp_done;

  mmc_addr_decode mmc_addr_decode_inst (
    .adr_i (cpu_adr_i),
    .tgt_o (tgt),
    .ofs_o (ofs)
  );

  // Unmapped target never stalls.
  always_comb
  begin
    tgt_stall = 1'b0;
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      if (tgt == tgt_t'(i))
      begin
        tgt_stall = slv_stall_i[i];
      end
    end
  end

  mmc_txn_tracker mmc_txn_tracker_inst (
    .clk         (clk),
    .rst         (rst),
    .cyc_i       (cpu_cyc_i),
    .stb_i       (cpu_stb_i),
    .tgt_i       (tgt),
    .tgt_stall_i (tgt_stall),
    .resp_done_i (resp_done),
    .issue_o     (issue),
    .accept_o    (accept),
    .stall_o     (cpu_stall_o),
    .owner_o     (owner)
  );

  // Request fields go to every slave, stb only to the decoded one.
  always_comb
  begin
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      slv_adr_o[i] = ofs;
      slv_dat_o[i] = cpu_dat_i;
      slv_we_o[i]  = cpu_we_i;
      slv_sel_o[i] = cpu_sel_i;
      slv_cyc_o[i] = cpu_cyc_i;
      slv_stb_o[i] = issue & (tgt == tgt_t'(i));
    end
  end

  assign null_accept = accept & (tgt == TGT_NULL);

  mmc_resp_mux mmc_resp_mux_inst (
    .clk           (clk),
    .rst           (rst),
    .owner_i       (owner),
    .null_accept_i (null_accept),
    .slv_ack_i     (slv_ack_i),
    .slv_err_i     (slv_err_i),
    .slv_dat_i     (slv_dat_i),
    .ack_o         (cpu_ack_o),
    .err_o         (cpu_err_o),
    .dat_o         (cpu_dat_o),
    .resp_done_o   (resp_done)
  );

endmodule
